// File: mbu_top.f
+incdir+common
common/mbu_pkg.sv
common/mbu_port_if.sv
common/mbu_access_if.sv
mbu/mbu_io_port.sv
mbu/mbu_access_decode.sv
mbu/mbu_bank_regs.sv
hdl/mbu_top.sv
bench/mbu_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mbu_tb
FILELIST  := mbu_top.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Verdict comes from the pass line in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/mbu_tb.sv
// Testbench for the memory bank unit with reference model, comparator, stimulus tasks and timeout
`timescale 1ns/1ps

module mbu_tb import mbu_pkg::*; ();

   // About 10 reset cycles, four ignored requests of 25 cycles, 48 write or read
   // handshakes of about 4 cycles, 40 index cycles and two stalls of about 45 cycles
   // That is well under 600 cycles, the limit leaves a wide margin
   localparam int cycle_limit    = 4000;
   localparam int ack_wait_limit = 200;
   localparam int no_ack_cycles  = 24;
   localparam int stall_cycles   = 40;

   logic     clk;
   logic     reset;
   cu_addr_t raddr;
   cu_addr_t waddr;
   mb_idx_t  ir;
   logic     ir_idx;
   mb_byte_t ibus_in;
   mb_byte_t ibus_out;
   logic     ibus_oe;
   logic     war;
   logic     io_req;
   logic     io_we;
   io_addr_t io_addr;
   mb_byte_t io_wdata;
   logic     io_ack;
   mb_byte_t io_rdata;
   logic     fp_ram_rom;
   mb_byte_t aext;

   // Reference model of the bank and the handshake in flight
   mb_byte_t mb_model [8];
   logic     en_model;
   logic     idx_prev;
   logic     ack_prev;
   logic     cu_busy_prev;
   logic     pend_active;
   logic     pend_we;
   mb_idx_t  pend_idx;
   mb_byte_t pend_wdata;
   string    test_name;
   int       cycles = 0;
   mb_idx_t  idx;
   mb_byte_t data;

   mbu_top dut0 (
      .clk        (clk),
      .reset      (reset),
      .raddr      (raddr),
      .waddr      (waddr),
      .ir         (ir),
      .ir_idx     (ir_idx),
      .ibus_in    (ibus_in),
      .ibus_out   (ibus_out),
      .ibus_oe    (ibus_oe),
      .war        (war),
      .io_req     (io_req),
      .io_we      (io_we),
      .io_addr    (io_addr),
      .io_wdata   (io_wdata),
      .io_ack     (io_ack),
      .io_rdata   (io_rdata),
      .fp_ram_rom (fp_ram_rom),
      .aext       (aext)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and checking
   ////////////////////////////////////////////////////////////////////////////

   // Disabled unit shows only the panel switch, enabled unit shows the indexed register
   function automatic mb_byte_t expect_aext(input logic en, input mb_idx_t ra, input logic fp);
      if (en) begin
         return mb_model[ra];
      end else begin
         return {fp, 7'b0};
      end
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_values(input string field, input mb_byte_t expected,
                                 input mb_byte_t actual);
      if (actual !== expected) begin
         fail_run($sformatf("mismatch %s %s expected %h actual %h", test_name, field,
                            expected, actual));
      end
   endtask

   // Samples at the rising edge, before any register in the DUT moves
   always @(posedge clk) begin : compare
      logic    rd_mbp;
      logic    wr_mbp;
      logic    wr_ar;
      logic    cu_busy;
      mb_idx_t ra;
      rd_mbp  = (raddr[4:1] == 4'b0110);
      wr_mbp  = (waddr[4:1] == 4'b0110);
      wr_ar   = (waddr[4:2] == 3'b001);
      cu_busy = rd_mbp | wr_mbp | wr_ar;
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            mb_model[i] = 8'h00;
         end
         en_model     = 1'b0;
         idx_prev     = 1'b0;
         ack_prev     = 1'b0;
         cu_busy_prev = 1'b0;
      end else begin
         // A rising ack means the I/O access landed at the previous edge
         // and that cycle must have been free of control-unit traffic
         if (io_ack && !ack_prev) begin
            compare_values("io_slot_free", 8'h00, {7'd0, cu_busy_prev});
            if (pend_we) begin
               mb_model[pend_idx] = pend_wdata;
               en_model           = 1'b1;
            end else begin
               compare_values("io_rdata", expect_aext(en_model, pend_idx, fp_ram_rom),
                              io_rdata);
            end
         end
         // Read port owner as seen by the control unit
         if (wr_ar && !rd_mbp) begin
            ra = (waddr[1:0] == 2'b11 && idx_prev) ? ir : {1'b0, waddr[1:0]};
         end else begin
            ra = 3'd0;
         end
         // An I/O read may borrow the idle read port in a cycle we cannot see
         if (!(pend_active && !pend_we && !rd_mbp && !wr_ar)) begin
            compare_values("aext", expect_aext(en_model, ra, fp_ram_rom), aext);
         end
         compare_values("ibus_oe", {7'd0, rd_mbp}, {7'd0, ibus_oe});
         compare_values("war", {7'd0, wr_ar}, {7'd0, war});
         if (rd_mbp) begin
            compare_values("ibus_out", expect_aext(en_model, 3'd0, fp_ram_rom), ibus_out);
         end
         // write_mbp lands at this very edge
         if (wr_mbp) begin
            mb_model[0] = ibus_in;
         end
         idx_prev     = ir_idx;
         ack_prev     = io_ack;
         cu_busy_prev = cu_busy;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         fail_run("run exceeded its cycle limit without finishing");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic apply_reset();
      @(negedge clk);
      reset = 1'b1;
      repeat (10) @(negedge clk);
      reset = 1'b0;
   endtask

   // One microcode cycle, held until the next falling edge
   task automatic cu_cycle(input cu_addr_t ra_v, input cu_addr_t wa_v, input mb_idx_t ir_v,
                           input logic idx_v, input mb_byte_t bus_v);
      @(negedge clk);
      raddr   = ra_v;
      waddr   = wa_v;
      ir      = ir_v;
      ir_idx  = idx_v;
      ibus_in = bus_v;
   endtask

   task automatic cu_idle();
      cu_cycle(5'd0, 5'd0, 3'd0, 1'b0, 8'h00);
   endtask

   // Random rmbp, wmbp or war every cycle, so the ports are never free
   task automatic cu_traffic(input int n);
      int       kind;
      mb_idx_t  ir_v;
      logic     idx_v;
      mb_byte_t bus_v;
      logic [1:0] low;
      repeat (n) begin
         kind  = int'($urandom_range(2, 0));
         ir_v  = mb_idx_t'($urandom);
         idx_v = 1'($urandom);
         bus_v = mb_byte_t'($urandom);
         low   = 2'($urandom);
         case (kind)
            0: cu_cycle({4'b0110, low[0]}, 5'd0, ir_v, idx_v, bus_v);
            1: cu_cycle(5'd0, {4'b0110, low[0]}, ir_v, idx_v, bus_v);
            default: cu_cycle(5'd0, {3'b001, low}, ir_v, idx_v, bus_v);
         endcase
         if (io_ack) begin
            fail_run("I/O request was acknowledged while the control unit held the ports");
         end
      end
   endtask

   // Full four-phase transfer
   task automatic io_handshake(input logic we, input io_addr_t addr, input mb_byte_t wd);
      int waited;
      @(negedge clk);
      io_req      = 1'b1;
      io_we       = we;
      io_addr     = addr;
      io_wdata    = wd;
      pend_we     = we;
      pend_idx    = addr[2:0];
      pend_wdata  = wd;
      pend_active = 1'b1;
      waited      = 0;
      while (!io_ack) begin
         @(negedge clk);
         waited++;
         if (waited > ack_wait_limit) begin
            fail_run($sformatf("I/O request to address %h was never acknowledged", addr));
         end
      end
      pend_active = 1'b0;
      io_req      = 1'b0;
      while (io_ack) begin
         @(negedge clk);
      end
   endtask

   task automatic io_write(input mb_idx_t i, input mb_byte_t d);
      io_handshake(1'b1, {5'b00001, i}, d);
   endtask

   task automatic io_read(input mb_idx_t i);
      io_handshake(1'b0, {5'b00001, i}, 8'h00);
   endtask

   // Outside the unit's window, so this wait is meant to run out
   task automatic io_no_ack(input io_addr_t addr);
      @(negedge clk);
      io_req   = 1'b1;
      io_we    = 1'b1;
      io_addr  = addr;
      io_wdata = mb_byte_t'($urandom);
      repeat (no_ack_cycles) begin
         @(negedge clk);
         if (io_ack) begin
            fail_run($sformatf("request to foreign address %h was acknowledged", addr));
         end
      end
      io_req = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(20014));
      reset       = 1'b1;
      raddr       = 5'd0;
      waddr       = 5'd0;
      ir          = 3'd0;
      ir_idx      = 1'b0;
      ibus_in     = 8'h00;
      io_req      = 1'b0;
      io_we       = 1'b0;
      io_addr     = 8'h00;
      io_wdata    = 8'h00;
      fp_ram_rom  = 1'b0;
      pend_active = 1'b0;
      pend_we     = 1'b0;
      pend_idx    = 3'd0;
      pend_wdata  = 8'h00;
      test_name   = "reset";
      apply_reset();

      // Disabled unit follows the switch, a write_mbp does not enable it
      test_name = "power_on";
      repeat (4) cu_idle();
      fp_ram_rom = 1'b1;
      repeat (4) cu_idle();
      cu_cycle(5'd0, 5'b01100, 3'd0, 1'b0, 8'ha5);
      repeat (3) cu_idle();
      @(posedge clk);
      compare_values("still_disabled", 8'h80, aext);
      cu_idle();
      fp_ram_rom = 1'b0;

      test_name = "io_foreign";
      io_no_ack(8'h00);
      io_no_ack(8'h07);
      io_no_ack(8'h10);
      io_no_ack(8'hf8);

      test_name = "io_write_read";
      for (int n = 0; n < 16; n++) begin
         idx  = mb_idx_t'($urandom);
         data = mb_byte_t'($urandom);
         io_write(idx, data);
         io_read(idx);
      end
      // Every register gets its own index in the low bits, so the index tests
      // below can tell any two registers apart
      for (int n = 0; n < 8; n++) begin
         data = {5'($urandom), 3'(n)};
         io_write(3'(n), data);
         io_read(3'(n));
      end

      // MB0 round trip through the internal bus
      test_name = "cu_mbp";
      data = mb_byte_t'($urandom);
      cu_cycle(5'd0, 5'b01101, 3'd0, 1'b0, data);
      cu_cycle(5'b01100, 5'd0, 3'd0, 1'b0, 8'h00);
      @(posedge clk);
      compare_values("ibus_out_mb0", data, ibus_out);
      compare_values("aext_mb0", data, aext);

      test_name = "cu_war";
      for (int k = 0; k < 3; k++) begin
         cu_cycle(5'd0, {3'b001, 2'(k)}, 3'd0, 1'b0, 8'h00);
         @(posedge clk);
         compare_values("aext_war", mb_model[k], aext);
      end
      for (int k = 0; k < 8; k++) begin
         cu_cycle(5'd0, 5'd0, 3'(k), 1'b0, 8'h00);
         cu_cycle(5'd0, 5'b00111, 3'(k), 1'b0, 8'h00);
         @(posedge clk);
         compare_values("aext_war_mb3", mb_model[3], aext);
         cu_cycle(5'd0, 5'd0, 3'(k), 1'b1, 8'h00);
         cu_cycle(5'd0, 5'b00111, 3'(k), 1'b0, 8'h00);
         @(posedge clk);
         compare_values("aext_war_ir", mb_model[k], aext);
      end
      cu_idle();

      // I/O waits out a stream of control-unit traffic, then completes
      test_name = "backpressure";
      idx  = mb_idx_t'($urandom);
      data = mb_byte_t'($urandom);
      fork
         begin
            cu_traffic(stall_cycles);
            cu_idle();
         end
         io_write(idx, data);
      join
      fork
         begin
            cu_traffic(stall_cycles);
            cu_idle();
         end
         io_read(idx);
      join
      repeat (4) cu_idle();

      $display("sim passed");
      $finish;
   end

endmodule

// File: hdl/mbu_top.sv
// Top level of the memory bank unit joining the I/O port, decode and bank stages
`timescale 1ns/1ps

module mbu_top import mbu_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   // Control-unit side
   input  cu_addr_t raddr,
   input  cu_addr_t waddr,
   input  mb_idx_t  ir,
   input  logic     ir_idx,
   input  mb_byte_t ibus_in,
   output mb_byte_t ibus_out,
   output logic     ibus_oe,
   output logic     war,
   // Processor I/O bus
   input  logic     io_req,
   input  logic     io_we,
   input  io_addr_t io_addr,
   input  mb_byte_t io_wdata,
   output logic     io_ack,
   output mb_byte_t io_rdata,
   // Front panel and memory side
   input  logic     fp_ram_rom,
   output mb_byte_t aext
);

   // Pending I/O request between the port and the decode stage
   mbu_port_if   port_bus ();

   // Arbitrated register access between decode and the bank
   mbu_access_if acc_bus ();

   mbu_io_port u_io_port (
      .clk      (clk),
      .reset    (reset),
      .io_req   (io_req),
      .io_we    (io_we),
      .io_addr  (io_addr),
      .io_wdata (io_wdata),
      .io_ack   (io_ack),
      .io_rdata (io_rdata),
      .port     (port_bus.source)
   );

   mbu_access_decode u_access_decode (
      .clk      (clk),
      .reset    (reset),
      .raddr    (raddr),
      .waddr    (waddr),
      .ir       (ir),
      .ir_idx   (ir_idx),
      .ibus_in  (ibus_in),
      .war      (war),
      .ibus_oe  (ibus_oe),
      .ibus_out (ibus_out),
      .port     (port_bus.sink),
      .acc      (acc_bus.master)
   );

   mbu_bank_regs u_bank_regs (
      .clk        (clk),
      .reset      (reset),
      .fp_ram_rom (fp_ram_rom),
      .aext       (aext),
      .acc        (acc_bus.slave)
   );

endmodule

// File: mbu/mbu_bank_regs.sv
// Eight bank registers, the unit enable flip-flop and forming of the aext output
`timescale 1ns/1ps
`include "mbu_defs.svh"

module mbu_bank_regs import mbu_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        fp_ram_rom,
   output mb_byte_t    aext,
   mbu_access_if.slave acc
);

   mb_byte_t mb [`MBU_NUM_REGS];
   logic     enabled;

   ////////////////////////////////////////////////////////////////////////////
   // Register file
   ////////////////////////////////////////////////////////////////////////////

   // One write port shared by write_mbp and I/O writes
   // Arbitration upstream guarantees at most one writer per cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `MBU_NUM_REGS; i++) begin
            mb[i] <= '0;
         end
      end else if (acc.wr) begin
         mb[acc.wa] <= acc.wdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Power-on default
   ////////////////////////////////////////////////////////////////////////////

   // The unit stays out of the way until software first writes a bank
   // register over I/O
   // From then on it drives aext until the next reset
   always_ff @(posedge clk) begin
      if (reset) begin
         enabled <= 1'b0;
      end else if (acc.io_wr && acc.wr) begin
         enabled <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Address extension
   ////////////////////////////////////////////////////////////////////////////

   // While disabled the front-panel switch alone decides between RAM and ROM
   // in the top half of the address space
   // Once enabled, the selected register goes straight out
   // With no read active ra rests on 0, so aext shows MBP
   assign aext = enabled ? mb[acc.ra] : {fp_ram_rom, 7'b0};

   // Reads for the internal bus and the I/O bus see exactly what aext shows
   assign acc.rdata = aext;

endmodule

// File: mbu/mbu_access_decode.sv
// Control-unit address decode, index mode latch and arbitration of the register ports
`timescale 1ns/1ps
`include "mbu_defs.svh"

module mbu_access_decode import mbu_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  cu_addr_t     raddr,
   input  cu_addr_t     waddr,
   input  mb_idx_t      ir,
   input  logic         ir_idx,
   input  mb_byte_t     ibus_in,
   output logic         war,
   output logic         ibus_oe,
   output mb_byte_t     ibus_out,
   mbu_port_if.sink     port,
   mbu_access_if.master acc
);

   logic    rmbp;
   logic    wmbp;
   logic    cu_busy;
   logic    idx_mode;
   mb_idx_t war_idx;
   rd_src_t rd_src;
   wr_src_t wr_src;

   ////////////////////////////////////////////////////////////////////////////
   // Control-unit decode
   ////////////////////////////////////////////////////////////////////////////

   // Partial decodes, the flag variants of read_mbp and write_mbp fold in
   assign rmbp = (raddr[4:1] == `MBU_RADDR_RMBP);
   assign wmbp = (waddr[4:1] == `MBU_WADDR_WMBP);
   assign war  = (waddr[4:2] == `MBU_WADDR_WAR);

   // Auto-index request from the control unit, seen one cycle late
   always_ff @(posedge clk) begin
      if (reset) begin
         idx_mode <= 1'b0;
      end else begin
         idx_mode <= ir_idx;
      end
   end

   // Indexing normally uses MBP, MBD, MBS or MB3 from waddr[1:0]
   // With the last slot and auto-index set, the instruction picks the register
   assign war_idx = (waddr[1:0] == 2'b11 && idx_mode) ? ir : {1'b0, waddr[1:0]};

   ////////////////////////////////////////////////////////////////////////////
   // Port arbitration
   ////////////////////////////////////////////////////////////////////////////

   // I/O gets a slot only when the control unit touches neither port
   assign cu_busy   = rmbp | war | wmbp;
   assign port.done = port.valid & ~cu_busy;

   always_comb begin
      rd_src = rd_none;
      if (rmbp) begin
         rd_src = rd_rmbp;
      end else if (war) begin
         rd_src = rd_war;
      end else if (port.done && !port.we) begin
         rd_src = rd_io;
      end
   end

   always_comb begin
      wr_src = wr_none;
      if (wmbp) begin
         wr_src = wr_wmbp;
      end else if (port.done && port.we) begin
         wr_src = wr_io;
      end
   end

   // MBP is register 0, and an idle read port also rests on it
   always_comb begin
      case (rd_src)
         rd_war:  acc.ra = war_idx;
         rd_io:   acc.ra = port.idx;
         default: acc.ra = '0;
      endcase
   end

   always_comb begin
      case (wr_src)
         wr_io: begin
            acc.wa    = port.idx;
            acc.wdata = port.wdata;
         end
         default: begin
            acc.wa    = '0;
            acc.wdata = ibus_in;
         end
      endcase
   end

   assign acc.wr    = (wr_src != wr_none);
   assign acc.io_wr = (wr_src == wr_io);

   // The bank answers at once, so I/O read data is ready in the done cycle
   assign port.rdata = acc.rdata;

   // read_mbp drives the internal bus with whatever the bank shows on aext
   assign ibus_oe  = rmbp;
   assign ibus_out = acc.rdata;

   // The microcode never reads MBP while indexing through it on the write side
   a_rmbp_war_excl: assert property (@(posedge clk) disable iff (reset)
      !(rmbp && war));

endmodule

// File: mbu/mbu_io_port.sv
// Four-phase req/ack slave for the processor I/O bus with address match and completion
`timescale 1ns/1ps
`include "mbu_defs.svh"

module mbu_io_port import mbu_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       io_req,
   input  logic       io_we,
   input  io_addr_t   io_addr,
   input  mb_byte_t   io_wdata,
   output logic       io_ack,
   output mb_byte_t   io_rdata,
   mbu_port_if.source port
);

   localparam io_addr_t io_base = `MBU_IO_BASE;

   // Idle waits for a matching request, pending holds it towards decode
   // and acked keeps io_ack up until the master lets go of io_req
   typedef enum logic [1:0] {
      st_idle,
      st_pending,
      st_acked
   } io_state_t;

   io_state_t state;
   logic      addr_match;
   logic      accept;
   logic      complete;

   // Addresses 0x08 to 0x0F all land here, bits 2:0 pick the register
   assign addr_match = (io_addr[7:3] == io_base[7:3]);

   // A request that does not match is simply never taken
   // The master sees no acknowledge and has to time out on its own
   assign accept   = (state == st_idle) && io_req && addr_match;
   assign complete = (state == st_pending) && port.done;

   ////////////////////////////////////////////////////////////////////////////
   // Handshake state
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= st_idle;
         port.valid <= 1'b0;
         io_ack     <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (accept) begin
                  port.valid <= 1'b1;
                  state      <= st_pending;
               end
            end
            st_pending: begin
               // The access happened this cycle, so acknowledge it next
               if (port.done) begin
                  port.valid <= 1'b0;
                  io_ack     <= 1'b1;
                  state      <= st_acked;
               end
            end
            st_acked: begin
               if (!io_req) begin
                  io_ack <= 1'b0;
                  state  <= st_idle;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Request fields and read data
   ////////////////////////////////////////////////////////////////////////////

   // The fields are captured once and stay put while the request is pending
   always_ff @(posedge clk) begin
      if (accept) begin
         port.we    <= io_we;
         port.idx   <= io_addr[2:0];
         port.wdata <= io_wdata;
      end
      // Read data is taken in the done cycle and held for the whole ack phase
      if (complete && !port.we) begin
         io_rdata <= port.rdata;
      end
   end

   // Once a request is taken the master must keep io_req up until it is acknowledged
   a_req_held: assert property (@(posedge clk) disable iff (reset)
      $fell(io_req) |-> (state != st_pending));

endmodule

// File: common/mbu_access_if.sv
// Interface with modports for the resolved register access from decode to the bank stage
`timescale 1ns/1ps

interface mbu_access_if import mbu_pkg::*; ();

   // Write port after arbitration
   // io_wr tells the bank that this write came in over the I/O bus
   logic     wr;
   mb_idx_t  wa;
   mb_byte_t wdata;
   logic     io_wr;

   // Read port after arbitration
   // The bank answers combinationally, so rdata follows ra in the same cycle
   mb_idx_t  ra;
   mb_byte_t rdata;

   // Decode side
   modport master (
      output wr,
      output wa,
      output wdata,
      output io_wr,
      output ra,
      input  rdata
   );

   // Register bank side
   modport slave (
      input  wr,
      input  wa,
      input  wdata,
      input  io_wr,
      input  ra,
      output rdata
   );

endinterface

// File: common/mbu_port_if.sv
// Interface with modports for one I/O request from the port stage to the decode stage
`timescale 1ns/1ps

interface mbu_port_if import mbu_pkg::*; ();

   // A request is pending while valid is high
   // The fields hold still until done has been high for one cycle
   logic     valid;
   logic     we;
   mb_idx_t  idx;
   mb_byte_t wdata;

   // Done marks the one cycle in which the register access really happens
   // For a read, rdata is only meaningful in that cycle
   logic     done;
   mb_byte_t rdata;

   // The port stage owns the request fields
   modport source (
      output valid,
      output we,
      output idx,
      output wdata,
      input  done,
      input  rdata
   );

   // The decode stage answers with completion and read data
   modport sink (
      input  valid,
      input  we,
      input  idx,
      input  wdata,
      output done,
      output rdata
   );

endinterface

// File: common/mbu_pkg.sv
// Types for register index, data byte, bus addresses and access kinds of the bank unit
package mbu_pkg;

   // Index of one of the eight bank registers
   typedef logic [2:0] mb_idx_t;

   // Register contents and internal bus data
   // Only the low byte of the data bus is carried
   typedef logic [7:0] mb_byte_t;

   // Control-unit microcode read and write addresses
   typedef logic [4:0] cu_addr_t;

   // Low byte of the processor I/O address bus
   typedef logic [7:0] io_addr_t;

   // Owner of the single register read port in one cycle
   // The control unit always wins over a pending I/O read
   typedef enum logic [1:0] {
      rd_none,
      rd_rmbp,
      rd_war,
      rd_io
   } rd_src_t;

   // Owner of the single register write port in one cycle
   // A write_mbp from the control unit always wins over an I/O write
   typedef enum logic [1:0] {
      wr_none,
      wr_wmbp,
      wr_io
   } wr_src_t;

endpackage

// File: common/mbu_defs.svh
// Macros for the I/O base address, the control-unit address codes and the register count
`ifndef MBU_DEFS_SVH
`define MBU_DEFS_SVH

// First I/O address of the bank unit
// The unit answers on eight consecutive addresses, so only bits 7:3 are compared
`define MBU_IO_BASE 8'h08

// Control-unit read address 0110x puts MBP on the internal bus
// Both read_mbp and read_mbp+flags share it, so raddr[4:1] is compared
`define MBU_RADDR_RMBP 4'b0110

// Control-unit write address 0110x loads MBP from the internal bus
// This is the same partial decode as the read side, on waddr[4:1]
`define MBU_WADDR_WMBP 4'b0110

// Control-unit write address 001xx is an address-register write with indexing
// The low two bits pick the bank register, so only waddr[4:2] is compared
`define MBU_WADDR_WAR 3'b001

// Number of bank registers MB0 to MB7
`define MBU_NUM_REGS 8

`endif
